// File: hw/gnn_bus_cfg.svh
`ifndef GNN_BUS_CFG_SVH
`define GNN_BUS_CFG_SVH

// Number of edge PEs sharing the bus.
`define NUM_EDGE_PE 4

// Node id width, also the address width of each memory.
`define NODE_ID_W 6

// Memory word width.
`define DATA_W 32

// Width of the PE number carried with each request.
`define PE_TAG_W 2

`endif

// File: hw/gnn_bus_pkg.sv
`include "gnn_bus_cfg.svh"

package gnn_bus_pkg;

    typedef logic [`NODE_ID_W-1:0]   node_id_t;
    typedef logic [`PE_TAG_W-1:0]    pe_tag_t;
    typedef logic [`DATA_W-1:0]      mem_word_t;
    typedef logic [`NUM_EDGE_PE-1:0] pe_mask_t;

    typedef enum logic [1:0] {
        req_neighbor = 2'b00,
        req_fv       = 2'b01,
        req_out_sram = 2'b10,
        req_reserved = 2'b11 // Granted, then dropped.
    } req_type_e;

    typedef struct packed {
        logic      req;
        req_type_e req_type;
        node_id_t  node_id;
        pe_tag_t   pe_tag;
    } pe_req_s;

    typedef struct packed {
        logic     valid;
        logic     rd_wr_en; // 0 means read.
        node_id_t node_id;
        pe_tag_t  pe_tag;
    } mem_req_s;

    typedef struct packed {
        logic      valid;
        pe_tag_t   pe_tag;
        mem_word_t data;
    } mem_rsp_s;

    typedef struct packed {
        logic      valid;
        req_type_e sel;    // Target memory.
        node_id_t  addr;
        mem_word_t data;
    } host_wr_s;

endpackage

// File: hw/rr_arbiter.sv
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module rr_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  gnn_bus_pkg::pe_mask_t reqs,
    output gnn_bus_pkg::pe_mask_t grants
);

    gnn_bus_pkg::pe_tag_t  ptr;       // Highest priority PE.
    gnn_bus_pkg::pe_tag_t  winner;
    gnn_bus_pkg::pe_mask_t nx_grants;
    logic                  found;

    // Search starts at the pointer and wraps around.
    always_comb begin
        int idx;
        nx_grants = '0;
        winner    = ptr;
        found     = 1'b0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            idx = (int'(ptr) + i) % `NUM_EDGE_PE;
            if (!found && reqs[idx]) begin
                found          = 1'b1;
                winner         = gnn_bus_pkg::pe_tag_t'(idx);
                nx_grants[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grants <= '0;
            ptr    <= '0;
        end else begin
            grants <= nx_grants;
            if (found) begin
                if (winner == gnn_bus_pkg::pe_tag_t'(`NUM_EDGE_PE - 1))
                    ptr <= '0;
                else
                    ptr <= winner + 1'b1; // Step past the winner.
            end
        end
    end

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module bus_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  gnn_bus_pkg::pe_req_s  pe_reqs [`NUM_EDGE_PE],
    output gnn_bus_pkg::pe_mask_t grant,
    output gnn_bus_pkg::mem_req_s neighbor_req,
    output gnn_bus_pkg::mem_req_s fv_req,
    output gnn_bus_pkg::mem_req_s out_sram_req
);

    gnn_bus_pkg::pe_mask_t req_mask;
    gnn_bus_pkg::pe_req_s  reg_reqs [`NUM_EDGE_PE]; // Aligned with the grant.
    gnn_bus_pkg::pe_req_s  granted;
    gnn_bus_pkg::pe_tag_t  granted_tag;
    gnn_bus_pkg::mem_req_s routed;
    gnn_bus_pkg::mem_req_s nx_neighbor_req;
    gnn_bus_pkg::mem_req_s nx_fv_req;
    gnn_bus_pkg::mem_req_s nx_out_sram_req;

    always_comb begin
        for (int i = 0; i < `NUM_EDGE_PE; i++)
            req_mask[i] = pe_reqs[i].req;
    end

    rr_arbiter i_rr_arbiter (
        .clk    (clk),
        .reset  (reset),
        .reqs   (req_mask),
        .grants (grant)
    );

    always_ff @(posedge clk) begin
        reg_reqs <= pe_reqs;
    end

    always_comb begin
        granted     = '0;
        granted_tag = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (grant[i]) begin
                granted     = reg_reqs[i];
                granted_tag = gnn_bus_pkg::pe_tag_t'(i); // Tag is the PE number.
            end
        end
        routed          = '{valid: 1'b1, rd_wr_en: 1'b0,
                            node_id: granted.node_id, pe_tag: granted_tag};
        nx_neighbor_req = '0;
        nx_fv_req       = '0;
        nx_out_sram_req = '0;
        if (|grant) begin
            case (granted.req_type)
                gnn_bus_pkg::req_neighbor: nx_neighbor_req = routed;
                gnn_bus_pkg::req_fv:       nx_fv_req       = routed;
                gnn_bus_pkg::req_out_sram: nx_out_sram_req = routed;
                default: ; // Reserved type goes nowhere.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            neighbor_req.valid <= 1'b0;
            fv_req.valid       <= 1'b0;
            out_sram_req.valid <= 1'b0;
        end else begin
            neighbor_req <= nx_neighbor_req;
            fv_req       <= nx_fv_req;
            out_sram_req <= nx_out_sram_req;
        end
    end

endmodule

// File: hw/info_mem_ctrl.sv
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module info_mem_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  gnn_bus_pkg::req_type_e mem_sel,  // Which memory this instance is.
    input  gnn_bus_pkg::host_wr_s  host_wr,
    input  gnn_bus_pkg::mem_req_s  mem_req,
    output gnn_bus_pkg::mem_rsp_s  mem_rsp
);

    localparam int DEPTH = 2 ** `NODE_ID_W;

    gnn_bus_pkg::mem_word_t mem [DEPTH];
    logic                   host_hit;
    logic                   rd_en;
    logic                   rsp_valid;
    gnn_bus_pkg::pe_tag_t   rsp_tag;
    gnn_bus_pkg::mem_word_t rsp_data;

    assign host_hit = host_wr.valid && (host_wr.sel == mem_sel);
    assign rd_en    = mem_req.valid && !mem_req.rd_wr_en;

    always_ff @(posedge clk) begin
        if (host_hit)
            mem[host_wr.addr] <= host_wr.data;
    end

    // Read data and tag come out one cycle after the request.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rsp_data <= mem[mem_req.node_id];
            rsp_tag  <= mem_req.pe_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_en;
    end

    always_comb begin
        mem_rsp.valid  = rsp_valid;
        mem_rsp.pe_tag = rsp_tag;
        mem_rsp.data   = rsp_data;
    end

endmodule

// File: hw/gnn_bus_top.sv
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module gnn_bus_top (
    input  logic                  clk,
    input  logic                  reset,
    input  gnn_bus_pkg::pe_req_s  pe_reqs [`NUM_EDGE_PE],
    input  gnn_bus_pkg::host_wr_s host_wr,
    output gnn_bus_pkg::pe_mask_t grant,
    output gnn_bus_pkg::mem_rsp_s neighbor_rsp,
    output gnn_bus_pkg::mem_rsp_s fv_rsp,
    output gnn_bus_pkg::mem_rsp_s out_sram_rsp
);

    gnn_bus_pkg::mem_req_s neighbor_req;
    gnn_bus_pkg::mem_req_s fv_req;
    gnn_bus_pkg::mem_req_s out_sram_req;

    bus_arbiter i_bus_arbiter (
        .clk          (clk),
        .reset        (reset),
        .pe_reqs      (pe_reqs),
        .grant        (grant),
        .neighbor_req (neighbor_req),
        .fv_req       (fv_req),
        .out_sram_req (out_sram_req)
    );

    info_mem_ctrl i_neighbor_mem (
        .clk     (clk),
        .reset   (reset),
        .mem_sel (gnn_bus_pkg::req_neighbor),
        .host_wr (host_wr),
        .mem_req (neighbor_req),
        .mem_rsp (neighbor_rsp)
    );

    info_mem_ctrl i_fv_mem (
        .clk     (clk),
        .reset   (reset),
        .mem_sel (gnn_bus_pkg::req_fv),
        .host_wr (host_wr),
        .mem_req (fv_req),
        .mem_rsp (fv_rsp)
    );

    info_mem_ctrl i_out_sram_mem (
        .clk     (clk),
        .reset   (reset),
        .mem_sel (gnn_bus_pkg::req_out_sram),
        .host_wr (host_wr),
        .mem_req (out_sram_req),
        .mem_rsp (out_sram_rsp)
    );

endmodule

// File: tests/gnn_bus_tb.sv
`timescale 1ns/1ps
`include "gnn_bus_cfg.svh"

module gnn_bus_tb;

    localparam int TIMEOUT = 20;
    localparam int DEPTH   = 2 ** `NODE_ID_W;

    typedef struct packed {
        int unsigned           due;  // Cycle at which the response must show.
        logic [1:0]            port;
        gnn_bus_pkg::mem_rsp_s rsp;
    } exp_rsp_s;

    logic                   clk;
    logic                   reset;
    gnn_bus_pkg::pe_req_s   pe_reqs [`NUM_EDGE_PE];
    gnn_bus_pkg::host_wr_s  host_wr;
    gnn_bus_pkg::pe_mask_t  grant;
    gnn_bus_pkg::mem_rsp_s  neighbor_rsp;
    gnn_bus_pkg::mem_rsp_s  fv_rsp;
    gnn_bus_pkg::mem_rsp_s  out_sram_rsp;

    gnn_bus_pkg::mem_word_t model_mem [3][DEPTH];
    exp_rsp_s               pending [$];  // Expected responses in grant order.
    gnn_bus_pkg::pe_tag_t   model_ptr;
    int unsigned            cycle;
    int                     pass_cnt;
    int                     fail_cnt;

    gnn_bus_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .pe_reqs      (pe_reqs),
        .host_wr      (host_wr),
        .grant        (grant),
        .neighbor_rsp (neighbor_rsp),
        .fv_rsp       (fv_rsp),
        .out_sram_rsp (out_sram_rsp)
    );

    always #4 clk = ~clk;

    function automatic string port_name(int p);
        case (p)
            0:       return "neighbor_rsp";
            1:       return "fv_rsp";
            default: return "out_sram_rsp";
        endcase
    endfunction

    function automatic gnn_bus_pkg::pe_mask_t held_reqs();
        gnn_bus_pkg::pe_mask_t m;
        for (int i = 0; i < `NUM_EDGE_PE; i++)
            m[i] = pe_reqs[i].req;
        return m;
    endfunction

    // First requester at or after the pointer wins.
    function automatic gnn_bus_pkg::pe_mask_t pick_rr(gnn_bus_pkg::pe_mask_t reqs,
                                                      gnn_bus_pkg::pe_tag_t ptr);
        for (int p = int'(ptr); p < `NUM_EDGE_PE; p++)
            if (reqs[p])
                return gnn_bus_pkg::pe_mask_t'(1) << p;
        for (int p = 0; p < int'(ptr); p++)
            if (reqs[p])
                return gnn_bus_pkg::pe_mask_t'(1) << p;
        return '0;
    endfunction

    function automatic logic bus_busy();
        return (held_reqs() != '0) || (pending.size() != 0);
    endfunction

    task automatic report_failure(string what);
        $display("%0t ns: %s", $time, what);
        fail_cnt++;
    endtask

    task automatic check_grant(gnn_bus_pkg::pe_mask_t exp, gnn_bus_pkg::pe_mask_t act);
        if (act !== exp) begin
            $display("error at %0t ns: grant expected %b, got %b", $time, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_rsp(string name, gnn_bus_pkg::mem_rsp_s exp,
                             gnn_bus_pkg::mem_rsp_s act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // Checks the grant, releases granted PEs and matches responses once per clock.
    task automatic step();
        gnn_bus_pkg::pe_mask_t exp_grant;
        gnn_bus_pkg::mem_rsp_s rsps [3];
        gnn_bus_pkg::pe_req_s  r;
        exp_rsp_s              e;
        @(negedge clk);
        cycle++;
        exp_grant = pick_rr(held_reqs(), model_ptr);
        check_grant(exp_grant, grant);
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            r = pe_reqs[i];
            if (exp_grant[i]) begin
                model_ptr = gnn_bus_pkg::pe_tag_t'((i + 1) % `NUM_EDGE_PE);
                if (r.req_type != gnn_bus_pkg::req_reserved) begin
                    e.due  = cycle + 2;  // Response 3 cycles after the request drive.
                    e.port = r.req_type;
                    e.rsp  = '{valid: 1'b1, pe_tag: gnn_bus_pkg::pe_tag_t'(i),
                               data: model_mem[r.req_type][r.node_id]};
                    pending.push_back(e);
                end
            end
            if (grant[i] === 1'b1)
                pe_reqs[i].req = 1'b0;
        end
        rsps = '{neighbor_rsp, fv_rsp, out_sram_rsp};
        for (int p = 0; p < 3; p++) begin
            if (rsps[p].valid !== 1'b0) begin
                if (pending.size() == 0) begin
                    report_failure($sformatf("response on %s with none outstanding",
                                             port_name(p)));
                end else begin
                    e = pending.pop_front();
                    if (e.due != cycle || int'(e.port) != p)
                        report_failure($sformatf("response on %s at wrong cycle or port",
                                                 port_name(p)));
                    check_rsp(port_name(p), e.rsp, rsps[p]);
                end
            end
        end
        if (pending.size() != 0 && pending[0].due < cycle) begin
            report_failure("an expected response never arrived");
            e = pending.pop_front();
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (bus_busy() && n < TIMEOUT) begin
            step();
            n++;
        end
        if (bus_busy()) begin
            $display("timeout: bus still busy after %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        for (int i = 0; i < `NUM_EDGE_PE; i++)
            pe_reqs[i] = '0;
        repeat (4) @(negedge clk);
        reset     = 1'b0;
        model_ptr = '0;
        pending.delete();
    endtask

    task automatic host_write(gnn_bus_pkg::req_type_e sel, gnn_bus_pkg::node_id_t addr,
                              gnn_bus_pkg::mem_word_t data);
        host_wr = '{valid: 1'b1, sel: sel, addr: addr, data: data};
        model_mem[sel][addr] = data;
        step();
        host_wr = '0;
    endtask

    task automatic request(int pe, gnn_bus_pkg::req_type_e t, gnn_bus_pkg::node_id_t node);
        pe_reqs[pe] = '{req: 1'b1, req_type: t, node_id: node,
                        pe_tag: gnn_bus_pkg::pe_tag_t'(pe)};
    endtask

    task automatic end_test(string name, int start_fails);
        if (fail_cnt == start_fails)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, fail_cnt - start_fails);
    endtask

    task automatic idle_after_reset();
        int start;
        start = fail_cnt;
        apply_reset();
        repeat (6) step();  // Grant and every response must stay quiet.
        end_test("reset_state", start);
    endtask

    task automatic read_each_memory();
        int start;
        start = fail_cnt;
        for (int m = 0; m < 3; m++)
            for (int a = 0; a < DEPTH; a++)
                host_write(gnn_bus_pkg::req_type_e'(m), gnn_bus_pkg::node_id_t'(a), $urandom());
        for (int m = 0; m < 3; m++) begin
            request(1, gnn_bus_pkg::req_type_e'(m),
                    gnn_bus_pkg::node_id_t'($urandom_range(0, DEPTH - 1)));
            wait_idle();
        end
        end_test("single_read", start);
    endtask

    task automatic round_robin_order();
        int start;
        start = fail_cnt;
        apply_reset();
        for (int i = 0; i < `NUM_EDGE_PE; i++)
            request(i, gnn_bus_pkg::req_type_e'(i % 3), gnn_bus_pkg::node_id_t'(i * 5));
        wait_idle();  // Grants 0, 1, 2, 3.
        request(2, gnn_bus_pkg::req_fv, 6'd9);
        wait_idle();
        request(0, gnn_bus_pkg::req_neighbor, 6'd1);
        request(1, gnn_bus_pkg::req_out_sram, 6'd2);
        request(3, gnn_bus_pkg::req_fv, 6'd3);
        wait_idle();  // Resumes at PE 3, then 0 and 1.
        end_test("round_robin", start);
    endtask

    task automatic random_back_to_back();
        int start;
        start = fail_cnt;
        repeat (40) begin
            for (int i = 0; i < `NUM_EDGE_PE; i++)
                if (!pe_reqs[i].req && $urandom_range(0, 3) != 0)
                    request(i, gnn_bus_pkg::req_type_e'($urandom_range(0, 3)),
                            gnn_bus_pkg::node_id_t'($urandom_range(0, DEPTH - 1)));
            step();
        end
        wait_idle();
        end_test("pipeline", start);
    endtask

    task automatic reserved_dropped();
        int start;
        start = fail_cnt;
        request(0, gnn_bus_pkg::req_reserved, 6'd3);
        wait_idle();
        repeat (TIMEOUT) step();  // Any response here is unexpected.
        end_test("reserved", start);
    endtask

    task automatic host_overwrite();
        int                     start;
        gnn_bus_pkg::mem_word_t new_word;
        start    = fail_cnt;
        new_word = ~model_mem[gnn_bus_pkg::req_fv][5];
        host_write(gnn_bus_pkg::req_fv, 6'd5, new_word);
        request(2, gnn_bus_pkg::req_fv, 6'd5);
        wait_idle();
        end_test("overwrite", start);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        host_wr   = '0;
        model_ptr = '0;
        cycle     = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        for (int i = 0; i < `NUM_EDGE_PE; i++)
            pe_reqs[i] = '0;
        void'($urandom(24));
        idle_after_reset();
        read_each_memory();
        round_robin_order();
        random_back_to_back();
        reserved_dropped();
        host_overwrite();
        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: gnn_bus.f
+incdir+hw
hw/gnn_bus_pkg.sv
hw/rr_arbiter.sv
hw/bus_arbiter.sv
hw/info_mem_ctrl.sv
hw/gnn_bus_top.sv
tests/gnn_bus_tb.sv

// File: Makefile
# Verilator build and run for the gnn_bus testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= gnn_bus_tb
FILELIST  ?= gnn_bus.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
SOURCES   := $(wildcard hw/*.sv hw/*.svh tests/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails when the log holds the fail message or the binary exits with an error.
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
